// File: Makefile
# Verilator build and run for the load/store pipeline testbench

VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation reads its trace relative to the project root
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
hw/lsu_pkg.sv
hw/exe_stage.sv
hw/mem_stage.sv
hw/wb_stage.sv
hw/data_sram.sv
hw/lsu_top.sv
sim/lsu_asserts.sv
sim/lsu_tb.sv

// File: hw/data_sram.sv
`timescale 1ns/1ns

module data_sram #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         en,
    input  logic [3:0]                   we,
    input  logic [$clog2(MEM_WORDS)-1:0] addr,
    input  logic [31:0]                  wdata,
    output logic [31:0]                  rdata
);

    logic [31:0] mem [MEM_WORDS];

    // start from a clean array in simulation
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'b0;
        end
    end

    // read returns the old word on a write
    always @(posedge clk) begin
        if (en) begin
            for (int b = 0; b < 4; b++) begin
                if (we[b]) begin
                    mem[addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
            rdata <= mem[addr];
        end
    end

endmodule

// File: hw/exe_stage.sv
`timescale 1ns/1ns

module exe_stage import lsu_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         ex_valid,
    input  ex_req_t                      ex_req,
    output logic                         ex_allowin,
    input  logic                         ms_allowin,
    output logic                         es_to_ms_valid,
    output es_to_ms_t                    es_to_ms_bus,
    output logic                         sram_en,
    output logic [3:0]                   sram_we,
    output logic [$clog2(MEM_WORDS)-1:0] sram_addr,
    output logic [31:0]                  sram_wdata
);

    localparam int ADDR_W = $clog2(MEM_WORDS);

    logic        es_valid;
    logic        es_ready_go;
    ex_req_t     es_req;
    logic [31:0] alu_result;
    logic        is_load;
    logic        is_store;
    logic [1:0]  sel;

    assign es_ready_go    = 1'b1;
    assign ex_allowin     = !es_valid || (es_ready_go && ms_allowin);
    assign es_to_ms_valid = es_valid && es_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (ex_allowin) begin
            es_valid <= ex_valid;
        end
        if (ex_valid && ex_allowin) begin
            es_req <= ex_req;
        end
    end

    // effective address, or the sum for op_add
    assign alu_result = es_req.base + es_req.offset;
    assign sel        = alu_result[1:0];

    assign is_load  = es_req.op inside {ld_b, ld_bu, ld_h, ld_hu, ld_w};
    assign is_store = es_req.op inside {st_b, st_h, st_w};

    assign es_to_ms_bus = '{
        op:           es_req.op,
        res_from_mem: is_load,
        gr_we:        !is_store,
        dest:         es_req.dest,
        alu_result:   alu_result,
        pc:           es_req.pc
    };

    // request only goes out on the transfer edge
    assign sram_en   = es_to_ms_valid && ms_allowin;
    assign sram_addr = alu_result[ADDR_W+1:2];

    always_comb begin
        sram_we    = 4'b0000;
        sram_wdata = {4{es_req.store_data[7:0]}};
        case (es_req.op)
            st_b: begin
                sram_we = 4'b0001 << sel;
            end
            st_h: begin
                sram_wdata = {2{es_req.store_data[15:0]}};
                // misaligned half writes nothing
                if (sel == 2'b00) begin
                    sram_we = 4'b0011;
                end else if (sel == 2'b10) begin
                    sram_we = 4'b1100;
                end
            end
            st_w: begin
                sram_wdata = es_req.store_data;
                sram_we    = (sel == 2'b00) ? 4'b1111 : 4'b0000;
            end
            default: begin
                sram_we = 4'b0000;
            end
        endcase
    end

endmodule

// File: hw/lsu_pkg.sv
package lsu_pkg;

    // op codes for the load/store path
    typedef enum logic [3:0] {
        op_add = 4'd0,
        ld_b   = 4'd1,
        ld_bu  = 4'd2,
        ld_h   = 4'd3,
        ld_hu  = 4'd4,
        ld_w   = 4'd5,
        st_b   = 4'd6,
        st_h   = 4'd7,
        st_w   = 4'd8
    } mem_op_e;

    // operation as it arrives from outside
    typedef struct packed {
        mem_op_e     op;
        logic [31:0] base;
        logic [31:0] offset;
        logic [31:0] store_data;
        logic [4:0]  dest;
        logic [31:0] pc;
    } ex_req_t;

    typedef struct packed {
        mem_op_e     op;
        logic        res_from_mem;
        logic        gr_we;
        logic [4:0]  dest;
        logic [31:0] alu_result;
        logic [31:0] pc;
    } es_to_ms_t;

    typedef struct packed {
        logic        gr_we;
        logic [4:0]  dest;
        logic [31:0] final_result;
        logic [31:0] pc;
    } ms_to_ws_t;

    typedef struct packed {
        logic        rf_we;
        logic [4:0]  dest;
        logic [31:0] data;
        logic [31:0] pc;
    } retire_t;

endpackage

// File: hw/lsu_top.sv
`timescale 1ns/1ns

module lsu_top import lsu_pkg::*; #(
    parameter int MEM_WORDS = 256,
    parameter int CNT_W     = 16
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             ex_valid,
    input  ex_req_t          ex_req,
    output logic             ex_allowin,
    input  logic             retire_ready,
    output logic             retire_valid,
    output retire_t          retire,
    output logic [CNT_W-1:0] retire_count
);

    localparam int ADDR_W = $clog2(MEM_WORDS);

    logic              es_to_ms_valid;
    es_to_ms_t         es_to_ms_bus;
    logic              ms_allowin;
    logic              ms_to_ws_valid;
    ms_to_ws_t         ms_to_ws_bus;
    logic              ws_allowin;
    logic              sram_en;
    logic [3:0]        sram_we;
    logic [ADDR_W-1:0] sram_addr;
    logic [31:0]       sram_wdata;
    logic [31:0]       sram_rdata;

    exe_stage #(
        .MEM_WORDS(MEM_WORDS)
    ) u_exe_stage (
        .clk            (clk),
        .reset          (reset),
        .ex_valid       (ex_valid),
        .ex_req         (ex_req),
        .ex_allowin     (ex_allowin),
        .ms_allowin     (ms_allowin),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .sram_en        (sram_en),
        .sram_we        (sram_we),
        .sram_addr      (sram_addr),
        .sram_wdata     (sram_wdata)
    );

    mem_stage u_mem_stage (
        .clk            (clk),
        .reset          (reset),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .ms_allowin     (ms_allowin),
        .ws_allowin     (ws_allowin),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .sram_rdata     (sram_rdata)
    );

    wb_stage #(
        .CNT_W(CNT_W)
    ) u_wb_stage (
        .clk            (clk),
        .reset          (reset),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .ws_allowin     (ws_allowin),
        .retire_ready   (retire_ready),
        .retire_valid   (retire_valid),
        .retire         (retire),
        .retire_count   (retire_count)
    );

    data_sram #(
        .MEM_WORDS(MEM_WORDS)
    ) u_data_sram (
        .clk   (clk),
        .en    (sram_en),
        .we    (sram_we),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

endmodule

// File: hw/mem_stage.sv
`timescale 1ns/1ns

module mem_stage import lsu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        es_to_ms_valid,
    input  es_to_ms_t   es_to_ms_bus,
    output logic        ms_allowin,
    input  logic        ws_allowin,
    output logic        ms_to_ws_valid,
    output ms_to_ws_t   ms_to_ws_bus,
    input  logic [31:0] sram_rdata
);

    logic        ms_valid;
    logic        ms_ready_go;
    es_to_ms_t   ms_bus;
    logic [1:0]  sel;
    logic [7:0]  byte_lane;
    logic [15:0] half_lane;
    logic        half_ok;
    logic [31:0] mem_result;
    logic [31:0] final_result;

    assign ms_ready_go    = 1'b1;
    assign ms_allowin     = !ms_valid || (ms_ready_go && ws_allowin);
    assign ms_to_ws_valid = ms_valid && ms_ready_go;

    // the one register that soaks up stalls
    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
        if (es_to_ms_valid && ms_allowin) begin
            ms_bus <= es_to_ms_bus;
        end
    end

    assign sel = ms_bus.alu_result[1:0];

    always_comb begin
        case (sel)
            2'b00:   byte_lane = sram_rdata[7:0];
            2'b01:   byte_lane = sram_rdata[15:8];
            2'b10:   byte_lane = sram_rdata[23:16];
            default: byte_lane = sram_rdata[31:24];
        endcase
    end

    // halves only at offsets 0 and 2
    assign half_lane = sel[1] ? sram_rdata[31:16] : sram_rdata[15:0];
    assign half_ok   = !sel[0];

    always_comb begin
        case (ms_bus.op)
            ld_b:    mem_result = {{24{byte_lane[7]}}, byte_lane};
            ld_bu:   mem_result = {24'b0, byte_lane};
            ld_h: begin
                mem_result = half_ok ? {{16{half_lane[15]}}, half_lane} : 32'b0;
            end
            ld_hu: begin
                mem_result = half_ok ? {16'b0, half_lane} : 32'b0;
            end
            default: mem_result = sram_rdata;
        endcase
    end

    assign final_result = ms_bus.res_from_mem ? mem_result : ms_bus.alu_result;

    assign ms_to_ws_bus = '{
        gr_we:        ms_bus.gr_we,
        dest:         ms_bus.dest,
        final_result: final_result,
        pc:           ms_bus.pc
    };

endmodule

// File: hw/wb_stage.sv
`timescale 1ns/1ns

module wb_stage import lsu_pkg::*; #(
    parameter int CNT_W = 16
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             ms_to_ws_valid,
    input  ms_to_ws_t        ms_to_ws_bus,
    output logic             ws_allowin,
    input  logic             retire_ready,
    output logic             retire_valid,
    output retire_t          retire,
    output logic [CNT_W-1:0] retire_count
);

    logic             ws_valid;
    logic             ws_ready_go;
    ms_to_ws_t        ws_bus;
    logic [CNT_W-1:0] count;

    assign ws_ready_go  = 1'b1;
    assign ws_allowin   = !ws_valid || (ws_ready_go && retire_ready);
    assign retire_valid = ws_valid && ws_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
        if (ms_to_ws_valid && ws_allowin) begin
            ws_bus <= ms_to_ws_bus;
        end
    end

    // r0 is hardwired, never written
    assign retire = '{
        rf_we: ws_bus.gr_we && (ws_bus.dest != 5'd0),
        dest:  ws_bus.dest,
        data:  ws_bus.final_result,
        pc:    ws_bus.pc
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (retire_valid && retire_ready) begin
            count <= count + 1'b1;
        end
    end

    assign retire_count = count;

endmodule

// File: sim/lsu_asserts.sv
`timescale 1ns/1ns

module lsu_asserts import lsu_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      es_to_ms_valid,
    input es_to_ms_t es_to_ms_bus,
    input logic      ms_allowin,
    input logic      ws_allowin,
    input logic      ms_to_ws_valid,
    input ms_to_ws_t ms_to_ws_bus
);

    // offer to write-back held while it is blocked
    ms_hold_valid: assert property (@(posedge clk) disable iff (reset)
        (ms_to_ws_valid && !ws_allowin) |=> ms_to_ws_valid)
        else $error("ms_to_ws_valid dropped while ws_allowin was low");

    ms_hold_bus: assert property (@(posedge clk) disable iff (reset)
        (ms_to_ws_valid && !ws_allowin) |=> $stable(ms_to_ws_bus))
        else $error("ms_to_ws_bus changed while ws_allowin was low");

    // same rule on the execute side of the buffer
    es_hold: assert property (@(posedge clk) disable iff (reset)
        (es_to_ms_valid && !ms_allowin) |=> (es_to_ms_valid && $stable(es_to_ms_bus)))
        else $error("execute offer changed while ms_allowin was low");

    empty_after_reset: assert property (@(posedge clk) reset |=> !ms_to_ws_valid)
        else $error("ms_to_ws_valid high in the cycle after reset");

endmodule

bind mem_stage lsu_asserts u_lsu_asserts (
    .clk            (clk),
    .reset          (reset),
    .es_to_ms_valid (es_to_ms_valid),
    .es_to_ms_bus   (es_to_ms_bus),
    .ms_allowin     (ms_allowin),
    .ws_allowin     (ws_allowin),
    .ms_to_ws_valid (ms_to_ws_valid),
    .ms_to_ws_bus   (ms_to_ws_bus)
);

// File: sim/lsu_tb.sv
`timescale 1ns/1ns

module lsu_tb import lsu_pkg::*; ();

    localparam int    CLK_PERIOD   = 40;
    localparam int    RESET_CYCLES = 16;
    localparam int    CYCLES_PER_OP = 40;
    localparam int    MEM_WORDS    = 256;
    localparam int    CNT_W        = 16;
    localparam string TRACE_FILE   = "sim/lsu_trace.txt";

    logic             clk;
    logic             reset;
    logic             ex_valid;
    ex_req_t          ex_req;
    logic             ex_allowin;
    logic             retire_ready;
    logic             retire_valid;
    retire_t          retire;
    logic [CNT_W-1:0] retire_count;

    ex_req_t     trace_req[$];
    retire_t     exp_q[$];
    int          n_ops = 0;
    int          retired = 0;
    logic        trace_ready = 1'b0;
    logic [31:0] lfsr = 32'h95ead382;

    lsu_top #(
        .MEM_WORDS(MEM_WORDS),
        .CNT_W(CNT_W)
    ) u_lsu_top (
        .clk          (clk),
        .reset        (reset),
        .ex_valid     (ex_valid),
        .ex_req       (ex_req),
        .ex_allowin   (ex_allowin),
        .retire_ready (retire_ready),
        .retire_valid (retire_valid),
        .retire       (retire),
        .retire_count (retire_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic next_random_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] got_val);
        $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp_val, got_val);
        abort_run();
    endtask

    task automatic load_trace();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] f_op, f_base, f_off, f_sdata;
        logic [31:0] f_dest, f_pc, f_we, f_data;
        ex_req_t     req;
        retire_t     exp_rec;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("could not open trace file %s", TRACE_FILE);
            abort_run();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                cnt = $fgets(line, fd);
                if (cnt > 0 && line.len() > 0 && line[0] != "#") begin
                    cnt = $sscanf(line, "%h %h %h %h %h %h %h %h", f_op, f_base, f_off,
                                  f_sdata, f_dest, f_pc, f_we, f_data);
                    if (cnt == 8) begin
                        req.op         = mem_op_e'(f_op[3:0]);
                        req.base       = f_base;
                        req.offset     = f_off;
                        req.store_data = f_sdata;
                        req.dest       = f_dest[4:0];
                        req.pc         = f_pc;
                        exp_rec.rf_we  = f_we[0];
                        exp_rec.dest   = f_dest[4:0];
                        exp_rec.data   = f_data;
                        exp_rec.pc     = f_pc;
                        trace_req.push_back(req);
                        exp_q.push_back(exp_rec);
                    end
                end
            end
            $fclose(fd);
        end
        if (trace_req.size() == 0) begin
            $display("trace file %s holds no operations", TRACE_FILE);
            abort_run();
        end
    endtask

    task automatic check_record(input retire_t got);
        retire_t exp_rec;
        if (exp_q.size() == 0) begin
            $display("retire record at %0t ns with nothing left to expect", $time);
            abort_run();
        end else begin
            exp_rec = exp_q.pop_front();
            assert (got.pc == exp_rec.pc)
                else report_mismatch("retire.pc", exp_rec.pc, got.pc);
            assert (got.rf_we == exp_rec.rf_we)
                else report_mismatch("retire.rf_we", 32'(exp_rec.rf_we), 32'(got.rf_we));
            assert (got.dest == exp_rec.dest)
                else report_mismatch("retire.dest", 32'(exp_rec.dest), 32'(got.dest));
            assert (got.data == exp_rec.data)
                else report_mismatch("retire.data", exp_rec.data, got.data);
        end
    endtask

    initial begin
        int   sent;
        logic busy;
        reset        = 1'b1;
        ex_valid     = 1'b0;
        ex_req       = '0;
        retire_ready = 1'b0;
        sent         = 0;
        load_trace();
        n_ops = trace_req.size();
        trace_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);

        // idle state out of reset
        assert (ex_allowin)
            else report_mismatch("ex_allowin", 32'd1, 32'(ex_allowin));
        assert (!retire_valid)
            else report_mismatch("retire_valid", 32'd0, 32'(retire_valid));
        assert (retire_count == '0)
            else report_mismatch("retire_count", 32'd0, 32'(retire_count));
        reset <= 1'b0;

        while (retired < n_ops) begin
            @(posedge clk);
            if (retire_valid && retire_ready) begin
                check_record(retire);
                retired++;
            end
            // hold an offer until it is taken
            busy = ex_valid && !ex_allowin;
            if (ex_valid && ex_allowin) begin
                sent++;
            end
            if (!busy) begin
                if (sent < n_ops && next_random_bit()) begin
                    ex_req   <= trace_req[sent];
                    ex_valid <= 1'b1;
                end else begin
                    ex_valid <= 1'b0;
                end
            end
            retire_ready <= next_random_bit();
        end

        retire_ready <= 1'b0;
        ex_valid     <= 1'b0;
        @(posedge clk);
        assert (retire_count == CNT_W'(n_ops))
            else report_mismatch("retire_count", 32'(n_ops), 32'(retire_count));
        assert (!retire_valid)
            else report_mismatch("retire_valid", 32'd0, 32'(retire_valid));
        if (exp_q.size() == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("%0d expected records never retired", exp_q.size());
            abort_run();
        end
    end

    initial begin
        wait (trace_ready);
        #((RESET_CYCLES + CYCLES_PER_OP * n_ops) * CLK_PERIOD);
        $display("timeout at %0t ns with %0d of %0d records retired", $time, retired, n_ops);
        abort_run();
    end

endmodule

// File: sim/lsu_trace.txt
# op base offset store_data dest pc, then expected rf_we data; all fields hex
# op codes 0 add, 1 ld_b, 2 ld_bu, 3 ld_h, 4 ld_hu, 5 ld_w, 6 st_b, 7 st_h, 8 st_w
0 00001000 00000234 00000000 01 1c000000 1 00001234
0 ffffffff 00000002 00000000 00 1c000004 0 00000001
8 00000100 00000000 11223344 00 1c000008 0 00000100
5 00000100 00000000 00000000 02 1c00000c 1 11223344
6 000000f0 00000011 000000aa 00 1c000010 0 00000101
6 00000100 00000003 0000ff80 00 1c000014 0 00000103
5 00000104 fffffffc 00000000 03 1c000018 1 8022aa44
7 00000100 00000002 0000c0de 00 1c00001c 0 00000102
7 00000100 00000001 00005555 00 1c000020 0 00000101
8 00000100 00000002 deadbeef 00 1c000024 0 00000102
5 00000100 00000000 00000000 04 1c000028 1 c0deaa44
1 00000100 00000000 00000000 05 1c00002c 1 00000044
1 00000100 00000001 00000000 06 1c000030 1 ffffffaa
1 00000100 00000002 00000000 07 1c000034 1 ffffffde
1 00000100 00000003 00000000 08 1c000038 1 ffffffc0
2 00000100 00000000 00000000 09 1c00003c 1 00000044
2 00000100 00000001 00000000 0a 1c000040 1 000000aa
2 00000100 00000002 00000000 0b 1c000044 1 000000de
2 00000100 00000003 00000000 0c 1c000048 1 000000c0
3 00000100 00000000 00000000 0d 1c00004c 1 ffffaa44
3 00000100 00000002 00000000 0e 1c000050 1 ffffc0de
4 00000100 00000000 00000000 0f 1c000054 1 0000aa44
4 00000100 00000002 00000000 10 1c000058 1 0000c0de
3 00000100 00000001 00000000 11 1c00005c 1 00000000
3 00000100 00000003 00000000 12 1c000060 1 00000000
7 000001f0 00000010 12347f01 00 1c000064 0 00000200
3 00000200 00000000 00000000 13 1c000068 1 00007f01
5 00000200 00000000 00000000 00 1c00006c 0 00007f01
6 00000200 00000002 000000e5 00 1c000070 0 00000202
6 00000200 00000000 00000099 00 1c000074 0 00000200
7 00000200 00000003 0000ffff 00 1c000078 0 00000203
5 00000200 00000000 00000000 14 1c00007c 1 00e57f99
0 00000300 fffffff0 00000000 1f 1c000080 1 000002f0
